/* rvv_mul_pkg.sv */
/*
  Shared definitions of the vector multiply unit:
  widths and counts, funct3/funct6 encodings, eew and vxrm enums,
  and the uop, control, result and partial-product structs
*/
`default_nettype none

package rvv_mul_pkg;

  //////////////////////////////
  // widths
  localparam int VLEN            = 128;
  localparam int VLENB           = VLEN / 8;
  localparam int XLEN            = 32;
  localparam int ROB_DEPTH_WIDTH = 4;
  localparam int N_MUL8          = 64;       // four 4x4 tiles

  typedef logic [5:0] funct6_t;
  typedef logic [2:0] funct3_t;

  //////////////////////////////
  // encodings
  localparam funct3_t OPIVV = 3'd0;
  localparam funct3_t OPMVV = 3'd2;
  localparam funct3_t OPIVX = 3'd4;
  localparam funct3_t OPMVX = 3'd6;

  localparam funct6_t VMUL    = 6'b100101;
  localparam funct6_t VMULH   = 6'b100111;
  localparam funct6_t VMULHU  = 6'b100100;
  localparam funct6_t VMULHSU = 6'b100110;
  localparam funct6_t VWMULU  = 6'b111000;
  localparam funct6_t VWMULSU = 6'b111010;
  localparam funct6_t VWMUL   = 6'b111011;
  localparam funct6_t VSMUL   = 6'b100111;  // same as VMULH, OPI space

  typedef enum logic [2:0] {
    EEW8  = 3'd0,
    EEW16 = 3'd1,
    EEW32 = 3'd2
  } eew_e;

  typedef enum logic [1:0] {
    RNU = 2'd0,                             // round to nearest up
    RNE = 2'd1,                             // round to nearest even
    RDN = 2'd2,                             // truncate
    ROD = 2'd3                              // round to odd
  } vxrm_e;

  //////////////////////////////
  // structs
  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    funct6_t                    funct6;
    funct3_t                    funct3;
    vxrm_e                      vxrm;
    eew_e                       vs2_eew;
    logic [VLEN-1:0]            vs1_data;
    logic [VLEN-1:0]            vs2_data;
    logic [XLEN-1:0]            rs1_data;
    logic                       uop_index;  // half select for widening
  } mul_uop_t;

  typedef struct packed {
    logic                       src2_signed;
    logic                       src1_signed;
    logic                       is_widen;
    logic                       keep_low;
    logic                       is_vsmul;
    vxrm_e                      vxrm;
    eew_e                       eew;
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
  } mul_ctrl_t;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]            w_data;
    logic                       w_valid;
    logic [VLENB-1:0]           vsaturate;
  } mul_rslt_t;

  typedef logic [N_MUL8-1:0][15:0] mul_prod_t;

endpackage

`default_nettype wire

/* rvv_mul8.sv */
/*
  8x8 multiplier, signedness chosen per input
*/
`timescale 1ns/1ps
`default_nettype none

module rvv_mul8 (
  input  logic [7:0]  in0,
  input  logic        in0_signed,
  input  logic [7:0]  in1,
  input  logic        in1_signed,
  output logic [15:0] out
);

  logic signed [8:0]  a;
  logic signed [8:0]  b;
  logic signed [17:0] p;

  assign a   = {in0_signed & in0[7], in0};     // 9-bit so unsigned stays positive
  assign b   = {in1_signed & in1[7], in1};
  assign p   = a * b;
  assign out = p[15:0];                        // any mix fits in 16 bits

endmodule

`default_nettype wire

/* rvv_mul_decode.sv */
/*
  Multiply uop decode: funct3/funct6 to control,
  operand select, scalar broadcast and per-byte sign vectors
*/
`timescale 1ns/1ps
`default_nettype none

module rvv_mul_decode
  import rvv_mul_pkg::*;
(
  input  logic             uop_valid,
  input  mul_uop_t         uop,
  output mul_ctrl_t        ctrl,
  output logic [VLEN-1:0]  src2,
  output logic [VLEN-1:0]  src1,
  output logic [VLENB-1:0] sign2,
  output logic [VLENB-1:0] sign1
);

  logic            is_opm;
  logic            is_opi;
  logic            is_vx;
  logic            op_ok;
  logic            s2_signed;
  logic            s1_signed;
  logic            widen;
  logic            keep_low;
  logic [VLEN-1:0] vs2_sel;
  logic [VLEN-1:0] vs1_sel;
  logic [VLEN-1:0] rs1_ext;
  logic [VLEN-1:0] rs1_bcast;

  assign is_opm = (uop.funct3 == OPMVV) || (uop.funct3 == OPMVX);
  assign is_opi = (uop.funct3 == OPIVV) || (uop.funct3 == OPIVX);
  assign is_vx  = (uop.funct3 == OPMVX) || (uop.funct3 == OPIVX);
  assign op_ok  = uop_valid && (is_opm || is_opi);

  always_comb begin
    s2_signed = 1'b1;
    s1_signed = 1'b1;
    widen     = 1'b0;
    keep_low  = 1'b0;
    if (is_opm) begin
      case (uop.funct6)
        VMUL:    keep_low = 1'b1;
        VMULH:   keep_low = 1'b0;
        VMULHU:  begin s2_signed = 1'b0; s1_signed = 1'b0; end
        VMULHSU: s1_signed = 1'b0;
        VWMUL:   widen = 1'b1;
        VWMULU:  begin widen = 1'b1; s2_signed = 1'b0; s1_signed = 1'b0; end
        VWMULSU: begin widen = 1'b1; s1_signed = 1'b0; end
        default: keep_low = 1'b1;             // falls back to vmul
      endcase
    end
    // whole OPI space runs as vsmul
  end

  // widening reads one 64-bit half, upper half zero
  assign vs2_sel = widen ? {64'b0, (uop.uop_index ? uop.vs2_data[127:64] : uop.vs2_data[63:0])}
                         : uop.vs2_data;
  assign vs1_sel = widen ? {64'b0, (uop.uop_index ? uop.vs1_data[127:64] : uop.vs1_data[63:0])}
                         : uop.vs1_data;
  assign rs1_ext = {{(VLEN-XLEN){uop.rs1_data[XLEN-1] & s1_signed}}, uop.rs1_data};

  // broadcast plus sign bit on top byte of each element
  always_comb begin
    case (uop.vs2_eew)
      EEW16: begin
        rs1_bcast = {8{rs1_ext[15:0]}};
        sign2     = {8{s2_signed, 1'b0}};
        sign1     = {8{s1_signed, 1'b0}};
      end
      EEW32: begin
        rs1_bcast = {4{rs1_ext[31:0]}};
        sign2     = {4{s2_signed, 3'b0}};
        sign1     = {4{s1_signed, 3'b0}};
      end
      default: begin                          // eew8
        rs1_bcast = {16{rs1_ext[7:0]}};
        sign2     = {16{s2_signed}};
        sign1     = {16{s1_signed}};
      end
    endcase
    if (!op_ok) begin
      sign2 = '0;
      sign1 = '0;
    end
  end

  assign src2 = op_ok ? vs2_sel : '0;
  assign src1 = !op_ok ? '0 : (is_vx ? rs1_bcast : vs1_sel);

  assign ctrl.src2_signed = op_ok & s2_signed;
  assign ctrl.src1_signed = op_ok & s1_signed;
  assign ctrl.is_widen    = op_ok & widen;
  assign ctrl.keep_low    = op_ok & keep_low;
  assign ctrl.is_vsmul    = op_ok & is_opi;
  assign ctrl.vxrm        = uop.vxrm;
  assign ctrl.eew         = uop.vs2_eew;
  assign ctrl.rob_entry   = uop.rob_entry;

  // the RS only issues 8/16/32-bit elements to this unit
  a_eew_legal: assert final (!uop_valid || (uop.vs2_eew inside {EEW8, EEW16, EEW32}))
    else $error("mul decode: illegal eew %0d", uop.vs2_eew);

endmodule

`default_nettype wire

/* rvv_mul_array.sv */
/*
  64 8x8 multipliers as four 4x4 tiles,
  with the stage register for products, control and valid
*/
`timescale 1ns/1ps
`default_nettype none

module rvv_mul_array
  import rvv_mul_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid,
  input  mul_ctrl_t        ctrl,
  input  logic [VLEN-1:0]  src2,
  input  logic [VLEN-1:0]  src1,
  input  logic [VLENB-1:0] sign2,
  input  logic [VLENB-1:0] sign1,
  output logic             valid_q,
  output mul_ctrl_t        ctrl_q,
  output mul_prod_t        prod_q
);

  localparam int TILES = 4;
  localparam int TDIM  = 4;                    // bytes per tile side

  mul_prod_t prod_d;

  //////////////////////////////
  // tile z covers bytes 4z..4z+3 of both sources
  // product index is z*16 + y*4 + x, x from src2, y from src1
  for (genvar z = 0; z < TILES; z++) begin : g_tile
    for (genvar x = 0; x < TDIM; x++) begin : g_col
      for (genvar y = 0; y < TDIM; y++) begin : g_row
        rvv_mul8 u_mul8 (
          .in0        (src2[(z*TDIM+x)*8 +: 8]),
          .in0_signed (sign2[z*TDIM+x]),
          .in1        (src1[(z*TDIM+y)*8 +: 8]),
          .in1_signed (sign1[z*TDIM+y]),
          .out        (prod_d[z*TDIM*TDIM + y*TDIM + x])
        );
      end
    end
  end

  //////////////////////////////
  // stage register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
      prod_q  <= '0;
    end else begin
      valid_q <= valid;
      ctrl_q  <= ctrl;                         // rides with the products
      prod_q  <= prod_d;
    end
  end

endmodule

`default_nettype wire

/* rvv_mul_elem_post.sv */
/*
  Per-element post-processing of a full product:
  low/high half, widening pass-through, vsmul rounding and saturation
*/
`timescale 1ns/1ps
`default_nettype none

module rvv_mul_elem_post
  import rvv_mul_pkg::*;
#(
  parameter int ELEM_W = 8
) (
  input  logic [2*ELEM_W-1:0] full,
  input  logic                keep_low,
  input  logic                is_widen,
  input  logic                is_vsmul,
  input  vxrm_e               vxrm,
  output logic [ELEM_W-1:0]   res_narrow,
  output logic [2*ELEM_W-1:0] res_wide,
  output logic                sat
);

  logic              d;
  logic              r;
  logic              rest_nz;
  logic              incr;
  logic              ovf;
  logic [ELEM_W-1:0] plain;
  logic [ELEM_W-1:0] rounded;

  // vsmul shifts right by ELEM_W-1, not ELEM_W
  assign d       = full[ELEM_W-1];             // lsb kept
  assign r       = full[ELEM_W-2];             // first dropped bit
  assign rest_nz = |full[ELEM_W-3:0];

  always_comb begin
    case (vxrm)
      RNU:     incr = r;
      RNE:     incr = r & (rest_nz | d);
      RDN:     incr = 1'b0;
      default: incr = ~d & (r | rest_nz);      // rod, jam into lsb
    endcase
  end

  // only min*min reaches 01 in the top bits
  assign ovf     = (full[2*ELEM_W-1 -: 2] == 2'b01);
  assign rounded = ovf ? {1'b0, {(ELEM_W-1){1'b1}}}
                       : full[2*ELEM_W-2 -: ELEM_W] + {{(ELEM_W-1){1'b0}}, incr};

  assign plain      = keep_low ? full[ELEM_W-1:0] : full[2*ELEM_W-1 -: ELEM_W];
  assign res_narrow = is_vsmul ? rounded : plain;
  assign res_wide   = is_widen ? full : {{ELEM_W{1'b0}}, res_narrow};
  assign sat        = is_vsmul & ovf;

endmodule

`default_nettype wire

/* rvv_mul_merge.sv */
/*
  Partial-product merge into 16/32/64-bit full products,
  element post-processing and the final select by eew
*/
`timescale 1ns/1ps
`default_nettype none

module rvv_mul_merge
  import rvv_mul_pkg::*;
(
  input  mul_prod_t        prod_q,
  input  mul_ctrl_t        ctrl_q,
  output logic [VLEN-1:0]  w_data,
  output logic [VLENB-1:0] vsaturate
);

  logic [15:0]       full8  [16];
  logic [31:0]       full16 [8];
  logic [63:0]       full32 [4];
  logic [VLEN-1:0]   narrow8;
  logic [VLEN-1:0]   narrow16;
  logic [VLEN-1:0]   narrow32;
  logic [2*VLEN-1:0] wide8;
  logic [2*VLEN-1:0] wide16;
  logic [2*VLEN-1:0] wide32;
  logic [15:0]       sat8;
  logic [7:0]        sat16;
  logic [3:0]        sat32;
  logic [VLENB-1:0]  vsat16;
  logic [VLENB-1:0]  vsat32;

  // src2 byte a times src1 byte b of an nb-byte element at byte base of tile z
  function automatic logic [63:0] pp_term(
    input mul_prod_t pp,
    input int        z,
    input int        base,
    input int        a,
    input int        b,
    input int        nb,
    input logic      s2,
    input logic      s1
  );
    logic [15:0] p;
    logic        ext;
    p   = pp[z*16 + (base+b)*4 + base + a];
    ext = p[15] & (((a == nb-1) & s2) | ((b == nb-1) & s1));  // signed top-byte term
    return {{48{ext}}, p} << (8*(a+b));
  endfunction

  //////////////////////////////
  // full products
  always_comb begin
    logic [63:0] acc;
    for (int e = 0; e < 16; e++) begin
      full8[e] = prod_q[(e/4)*16 + (e%4)*5];  // diagonal of the tile
    end
    for (int e = 0; e < 8; e++) begin
      acc = '0;
      for (int a = 0; a < 2; a++) begin
        for (int b = 0; b < 2; b++) begin
          acc = acc + pp_term(prod_q, e/2, (e%2)*2, a, b, 2,
                              ctrl_q.src2_signed, ctrl_q.src1_signed);
        end
      end
      full16[e] = acc[31:0];
    end
    for (int e = 0; e < 4; e++) begin
      acc = '0;
      for (int a = 0; a < 4; a++) begin
        for (int b = 0; b < 4; b++) begin
          acc = acc + pp_term(prod_q, e, 0, a, b, 4,
                              ctrl_q.src2_signed, ctrl_q.src1_signed);
        end
      end
      full32[e] = acc;                         // whole tile
    end
  end

  //////////////////////////////
  // per-element post
  for (genvar e = 0; e < 16; e++) begin : g_e8
    rvv_mul_elem_post #(.ELEM_W(8)) u_post (
      .full       (full8[e]),
      .keep_low   (ctrl_q.keep_low),
      .is_widen   (ctrl_q.is_widen),
      .is_vsmul   (ctrl_q.is_vsmul),
      .vxrm       (ctrl_q.vxrm),
      .res_narrow (narrow8[e*8 +: 8]),
      .res_wide   (wide8[e*16 +: 16]),
      .sat        (sat8[e])
    );
  end

  for (genvar e = 0; e < 8; e++) begin : g_e16
    rvv_mul_elem_post #(.ELEM_W(16)) u_post (
      .full       (full16[e]),
      .keep_low   (ctrl_q.keep_low),
      .is_widen   (ctrl_q.is_widen),
      .is_vsmul   (ctrl_q.is_vsmul),
      .vxrm       (ctrl_q.vxrm),
      .res_narrow (narrow16[e*16 +: 16]),
      .res_wide   (wide16[e*32 +: 32]),
      .sat        (sat16[e])
    );
  end

  for (genvar e = 0; e < 4; e++) begin : g_e32
    rvv_mul_elem_post #(.ELEM_W(32)) u_post (
      .full       (full32[e]),
      .keep_low   (ctrl_q.keep_low),
      .is_widen   (ctrl_q.is_widen),
      .is_vsmul   (ctrl_q.is_vsmul),
      .vxrm       (ctrl_q.vxrm),
      .res_narrow (narrow32[e*32 +: 32]),
      .res_wide   (wide32[e*64 +: 64]),
      .sat        (sat32[e])
    );
  end

  //////////////////////////////
  // saturation flag sits on the top byte of its element
  always_comb begin
    vsat16 = '0;
    vsat32 = '0;
    for (int e = 0; e < 8; e++) begin
      vsat16[2*e+1] = sat16[e];
    end
    for (int e = 0; e < 4; e++) begin
      vsat32[4*e+3] = sat32[e];
    end
  end

  // widening keeps the low half of the wide vector
  always_comb begin
    case (ctrl_q.eew)
      EEW16: begin
        w_data    = ctrl_q.is_widen ? wide16[VLEN-1:0] : narrow16;
        vsaturate = vsat16;
      end
      EEW32: begin
        w_data    = ctrl_q.is_widen ? wide32[VLEN-1:0] : narrow32;
        vsaturate = vsat32;
      end
      default: begin
        w_data    = ctrl_q.is_widen ? wide8[VLEN-1:0] : narrow8;
        vsaturate = sat8;
      end
    endcase
  end

  // decode never flags a widening vsmul
  a_widen_vsmul: assert final (!(ctrl_q.is_widen && ctrl_q.is_vsmul))
    else $error("mul merge: widen and vsmul both set");

endmodule

`default_nettype wire

/* rvv_mul_unit.sv */
/*
  Vector multiply unit top: decode, multiplier array
  with its stage register, merge, and the ROB result pack
*/
`timescale 1ns/1ps
`default_nettype none

module rvv_mul_unit
  import rvv_mul_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      uop_valid,
  input  mul_uop_t  uop,
  output logic      rslt_valid,
  output mul_rslt_t rslt
);

  mul_ctrl_t        ctrl;
  mul_ctrl_t        ctrl_q;
  logic [VLEN-1:0]  src2;
  logic [VLEN-1:0]  src1;
  logic [VLENB-1:0] sign2;
  logic [VLENB-1:0] sign1;
  logic             valid_q;
  mul_prod_t        prod_q;
  logic [VLEN-1:0]  w_data;
  logic [VLENB-1:0] vsaturate;

  rvv_mul_decode u_decode (
    .uop_valid (uop_valid),
    .uop       (uop),
    .ctrl      (ctrl),
    .src2      (src2),
    .src1      (src1),
    .sign2     (sign2),
    .sign1     (sign1)
  );

  rvv_mul_array u_array (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (uop_valid),
    .ctrl    (ctrl),
    .src2    (src2),
    .src1    (src1),
    .sign2   (sign2),
    .sign1   (sign1),
    .valid_q (valid_q),
    .ctrl_q  (ctrl_q),
    .prod_q  (prod_q)
  );

  rvv_mul_merge u_merge (
    .prod_q    (prod_q),
    .ctrl_q    (ctrl_q),
    .w_data    (w_data),
    .vsaturate (vsaturate)
  );

  //////////////////////////////
  // result to ROB
  assign rslt_valid     = valid_q;
  assign rslt.rob_entry = ctrl_q.rob_entry;
  assign rslt.w_data    = w_data;
  assign rslt.w_valid   = valid_q;
  assign rslt.vsaturate = vsaturate;

  // fixed one-cycle latency, no stalls
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (rslt_valid == $past(uop_valid)))
    else $error("mul unit: result valid does not follow uop valid by one cycle");

endmodule

`default_nettype wire

/* tb_rvv_mul_unit.sv */
/*
  Directed testbench of the vector multiply unit:
  reference model, LFSR operands, check task and cycle timeout
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_mul_unit
  import rvv_mul_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 3;
  localparam logic [31:0] SEED  = 32'd90341;
  localparam int N_UOPS         = 65;          // sum over all tests below
  localparam int CYCLES_PER_UOP = 2;
  localparam int MARGIN         = 20;
  localparam int MAX_CYCLES     = RESET_CYCLES + N_UOPS * CYCLES_PER_UOP + MARGIN;

  logic                       clk;
  logic                       rst_n;
  logic                       uop_valid;
  mul_uop_t                   uop;
  logic                       rslt_valid;
  mul_rslt_t                  rslt;
  logic [31:0]                lfsr;
  logic [ROB_DEPTH_WIDTH-1:0] rob_cnt;
  int                         cycle_cnt = 0;

  rvv_mul_unit uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .rslt_valid (rslt_valid),
    .rslt       (rslt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "simulation timed out");
    end
  end

  //////////////////////////////
  // helpers
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  task automatic rand_bits(input int n, output logic [VLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];                          // one step per bit
    end
  endtask

  function automatic logic [63:0] mask_w(input int w);
    return (w >= 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
  endfunction

  function automatic logic [63:0] elem(input logic [VLEN-1:0] v, input int idx, input int w);
    logic [VLEN-1:0] t;
    t = v >> (idx * w);
    return t[63:0] & mask_w(w);
  endfunction

  // w-bit operands, each extended by its own signedness
  function automatic logic [63:0] mul_ref(input logic [63:0] a, input logic [63:0] b,
                                          input int w, input logic sa, input logic sb);
    logic signed [64:0] ea;
    logic signed [64:0] eb;
    logic signed [64:0] p;
    ea = {1'b0, a};
    eb = {1'b0, b};
    if (sa && a[w-1])
      ea = ea | ({65{1'b1}} << w);
    if (sb && b[w-1])
      eb = eb | ({65{1'b1}} << w);
    p = ea * eb;
    return p[63:0];
  endfunction

  function automatic mul_uop_t make_uop(input funct6_t f6, input funct3_t f3, input int k,
                                        input int rm, input logic [VLEN-1:0] vs2,
                                        input logic [VLEN-1:0] vs1,
                                        input logic [XLEN-1:0] rs1, input logic idx);
    mul_uop_t u;
    u           = '0;
    u.funct6    = f6;
    u.funct3    = f3;
    u.vs2_eew   = eew_e'(k);
    u.vxrm      = vxrm_e'(rm);
    u.vs2_data  = vs2;
    u.vs1_data  = vs1;
    u.rs1_data  = rs1;
    u.uop_index = idx;
    return u;
  endfunction

  //////////////////////////////
  // reference model
  task automatic model_result(input mul_uop_t u, output logic [VLEN-1:0] data,
                              output logic [VLENB-1:0] sat);
    int              w;
    int              n;
    int              base;
    logic            opi;
    logic            vx;
    logic            s2;
    logic            s1;
    logic            widen;
    logic            low;
    logic [63:0]     a;
    logic [63:0]     b;
    logic [63:0]     full;
    logic [63:0]     res;
    logic            d;
    logic            r;
    logic            rest;
    logic            incr;
    logic [VLEN-1:0] sh;
    w     = 8 << int'(u.vs2_eew);
    opi   = (u.funct3 == OPIVV) || (u.funct3 == OPIVX);
    vx    = (u.funct3 == OPIVX) || (u.funct3 == OPMVX);
    s2    = 1'b1;
    s1    = 1'b1;
    widen = 1'b0;
    low   = 1'b0;
    if (!opi) begin
      case (u.funct6)
        VMULH: low = 1'b0;
        VMULHU: begin
          s2 = 1'b0;
          s1 = 1'b0;
        end
        VMULHSU: s1 = 1'b0;
        VWMUL: widen = 1'b1;
        VWMULU: begin
          widen = 1'b1;
          s2    = 1'b0;
          s1    = 1'b0;
        end
        VWMULSU: begin
          widen = 1'b1;
          s1    = 1'b0;
        end
        default: low = 1'b1;                   // vmul
      endcase
    end
    data = '0;
    sat  = '0;
    n    = widen ? 64 / w : VLEN / w;
    base = (widen && u.uop_index) ? n : 0;
    for (int i = 0; i < n; i++) begin
      a    = elem(u.vs2_data, base + i, w);
      b    = vx ? ({32'b0, u.rs1_data} & mask_w(w)) : elem(u.vs1_data, base + i, w);
      full = mul_ref(a, b, w, s2, s1) & mask_w(2 * w);
      if (widen) begin
        res = full;
      end else if (opi) begin
        d    = full[w-1];
        r    = full[w-2];
        rest = (full & mask_w(w - 2)) != 0;
        case (u.vxrm)
          RNU:     incr = r;
          RNE:     incr = r & (rest | d);
          RDN:     incr = 1'b0;
          default: incr = !d & (r | rest);
        endcase
        if (!full[2*w-1] && full[2*w-2]) begin
          res = mask_w(w - 1);                 // max positive
          sat[(i + 1) * (w / 8) - 1] = 1'b1;
        end else begin
          res = ((full >> (w - 1)) + incr) & mask_w(w);
        end
      end else if (low) begin
        res = full & mask_w(w);
      end else begin
        res = full >> w;
      end
      sh   = res;
      data = data | (sh << (i * (widen ? 2 * w : w)));
    end
  endtask

  //////////////////////////////
  // checks
  task automatic check(input string name, input logic [VLEN-1:0] exp,
                       input logic [VLEN-1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "first mismatch, run stopped");
    end
  endtask

  task automatic compare_result(input string name, input mul_uop_t u);
    logic [VLEN-1:0]  exp_data;
    logic [VLENB-1:0] exp_sat;
    model_result(u, exp_data, exp_sat);
    check($sformatf("%s valid", name), 1, rslt_valid);
    check($sformatf("%s w_valid", name), 1, rslt.w_valid);
    check($sformatf("%s rob", name), u.rob_entry, rslt.rob_entry);
    check($sformatf("%s data", name), exp_data, rslt.w_data);
    check($sformatf("%s vsat", name), exp_sat, rslt.vsaturate);
  endtask

  // one uop in, result sampled mid-cycle after the capture edge
  task automatic apply(input string name, input mul_uop_t u);
    u.rob_entry = rob_cnt;
    rob_cnt     = rob_cnt + 1;
    @(posedge clk);
    uop       <= u;
    uop_valid <= 1'b1;
    @(posedge clk);
    uop_valid <= 1'b0;
    @(negedge clk);
    compare_result(name, u);
  endtask

  //////////////////////////////
  // directed tests
  task automatic test_vmul_vv();
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vs1;
    for (int k = 0; k < 3; k++) begin
      for (int rep = 0; rep < 2; rep++) begin
        rand_bits(VLEN, vs2);
        rand_bits(VLEN, vs1);
        apply($sformatf("vmul_vv_e%0d", 8 << k), make_uop(VMUL, OPMVV, k, 0, vs2, vs1, '0, 1'b0));
      end
    end
  endtask

  task automatic test_vmulh();
    funct6_t         ops [3];
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vs1;
    ops = '{VMULH, VMULHU, VMULHSU};
    for (int o = 0; o < 3; o++) begin
      for (int k = 0; k < 3; k++) begin
        rand_bits(VLEN, vs2);
        rand_bits(VLEN, vs1);
        apply($sformatf("vmulh_op%0d_e%0d", o, 8 << k),
              make_uop(ops[o], OPMVV, k, 0, vs2, vs1, '0, 1'b0));
      end
    end
  endtask

  task automatic test_vx();
    funct6_t         ops [2];
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] rs1;
    ops = '{VMUL, VMULH};
    for (int o = 0; o < 2; o++) begin
      for (int k = 0; k < 3; k++) begin
        rand_bits(VLEN, vs2);
        rand_bits(XLEN, rs1);
        apply($sformatf("vx_op%0d_e%0d", o, 8 << k),
              make_uop(ops[o], OPMVX, k, 0, vs2, '0, rs1[XLEN-1:0], 1'b0));
      end
    end
  endtask

  task automatic test_widen();
    funct6_t         ops [3];
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vs1;
    ops = '{VWMUL, VWMULU, VWMULSU};
    for (int o = 0; o < 3; o++) begin
      for (int k = 0; k < 3; k++) begin
        for (int idx = 0; idx < 2; idx++) begin
          rand_bits(VLEN, vs2);
          rand_bits(VLEN, vs1);
          apply($sformatf("vwmul_op%0d_e%0d_i%0d", o, 8 << k, idx),
                make_uop(ops[o], OPMVV, k, 0, vs2, vs1, '0, idx[0]));
        end
      end
    end
  endtask

  task automatic test_vsmul();
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vs1;
    logic [VLEN-1:0] lo_mask;
    logic [VLEN-1:0] min_val;
    int              w;
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 3; k++) begin
        w = 8 << k;
        rand_bits(VLEN, vs2);
        rand_bits(VLEN, vs1);
        apply($sformatf("vsmul_rm%0d_e%0d", m, w), make_uop(VSMUL, OPIVV, k, m, vs2, vs1, '0, 1'b0));
        // element 0 of both sources at the most negative value
        lo_mask = (128'd1 << w) - 1;
        min_val = 128'd1 << (w - 1);
        vs2     = (vs2 & ~lo_mask) | min_val;
        vs1     = (vs1 & ~lo_mask) | min_val;
        apply($sformatf("vsmul_min_rm%0d_e%0d", m, w),
              make_uop(VSMUL, OPIVV, k, m, vs2, vs1, '0, 1'b0));
        check($sformatf("vsmul_min_rm%0d_e%0d max", m, w), min_val - 1, rslt.w_data & lo_mask);
        check($sformatf("vsmul_min_rm%0d_e%0d flag", m, w), 1, rslt.vsaturate[w/8-1]);
      end
    end
  endtask

  task automatic test_pipeline();
    mul_uop_t        ua;
    mul_uop_t        ub;
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vs1;
    rand_bits(VLEN, vs2);
    rand_bits(VLEN, vs1);
    ua           = make_uop(VMUL, OPMVV, 1, 0, vs2, vs1, '0, 1'b0);
    ua.rob_entry = 4'd5;
    rand_bits(VLEN, vs2);
    rand_bits(VLEN, vs1);
    ub           = make_uop(VMULHU, OPMVV, 2, 0, vs2, vs1, '0, 1'b0);
    ub.rob_entry = 4'd10;
    @(posedge clk);
    uop       <= ua;
    uop_valid <= 1'b1;
    @(posedge clk);
    uop       <= ub;                           // back to back
    @(negedge clk);
    compare_result("pipe_first", ua);
    @(posedge clk);
    uop_valid <= 1'b0;
    @(negedge clk);
    compare_result("pipe_second", ub);
    @(posedge clk);
    @(negedge clk);
    check("pipe_idle valid", 0, rslt_valid);
  endtask

  //////////////////////////////
  // main sequence
  initial begin
    rst_n     = 1'b0;
    uop_valid = 1'b0;
    uop       = '0;
    lfsr      = SEED;
    rob_cnt   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("reset valid", 0, rslt_valid);
    test_vmul_vv();
    test_vmulh();
    test_vx();
    test_widen();
    test_vsmul();
    test_pipeline();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
rvv_mul_pkg.sv
rvv_mul8.sv
rvv_mul_decode.sv
rvv_mul_array.sv
rvv_mul_elem_post.sv
rvv_mul_merge.sv
rvv_mul_unit.sv
tb_rvv_mul_unit.sv

/* Bender.yml */
package:
  name: rvv_mul_unit

sources:
  - rvv_mul_pkg.sv
  - rvv_mul8.sv
  - rvv_mul_decode.sv
  - rvv_mul_array.sv
  - rvv_mul_elem_post.sv
  - rvv_mul_merge.sv
  - rvv_mul_unit.sv
  - target: test
    files:
      - tb_rvv_mul_unit.sv
